// ==== verilog/datapath_pkg.sv ====
// datapath package with the ISA encoding, bundles and width constants
package datapath_pkg;

    // data and register file geometry
    localparam int XLEN  = 16;
    localparam int NREG  = 8;
    localparam int REG_W = 3;

    // 4-bit operation encoding
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_LI   = 4'd7,
        OP_HALT = 4'd15
    } opcode_t;

    // instruction word as it arrives on the instruction port, 24 bits
    typedef struct packed {
        opcode_t          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [7:0]       imm;
        logic [2:0]       pad;
    } instr_t;

    // operands already read from the register file
    typedef struct packed {
        opcode_t          op;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  opa;
        logic [XLEN-1:0]  opb;
        logic [7:0]       imm;
    } issue_t;

    // one result headed for the register file
    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  wdat;
    } wb_t;

    // execution lane state
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_BUSY = 2'd1,
        LANE_DONE = 2'd2
    } lane_state_t;

endpackage

// ==== verilog/fetch_stage.sv ====
// fetch stage, receiving side of the four-phase instruction port with a one-entry buffer
`timescale 1ns/1ps

module fetch_stage
    import datapath_pkg::*;
(
    input  logic   CLK,
    input  logic   nrst,
    input  logic   instr_req,
    input  instr_t instr,
    output logic   instr_ack,
    output logic   fetch_valid,
    output instr_t fetch_instr,
    input  logic   fetch_take
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } hs_state_t;

    hs_state_t state;
    logic      buf_valid;
    instr_t    buf_instr;
    logic      capture;

    // only take a new word when the buffer has been emptied
    assign capture = (state == WAIT_REQ) && instr_req && !buf_valid;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state     <= WAIT_REQ;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (capture) begin
                        state <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // source has released, ack can fall
                    if (!instr_req) begin
                        state <= WAIT_REQ;
                    end
                end
                default: state <= WAIT_REQ;
            endcase

            if (capture) begin
                buf_valid <= 1'b1;
            end else if (fetch_take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // payload, qualified by buf_valid
    always_ff @(posedge CLK) begin
        if (capture) begin
            buf_instr <= instr;
        end
    end

    assign instr_ack   = (state == WAIT_DROP);
    assign fetch_valid = buf_valid;
    assign fetch_instr = buf_instr;

endmodule

// ==== verilog/scoreboard.sv ====
// scoreboard with register file, busy tracking, hazard stall, lane pick and halt detection
`timescale 1ns/1ps

module scoreboard
    import datapath_pkg::*;
#(
    parameter int N_LANES = 3
)
(
    input  logic               CLK,
    input  logic               nrst,
    input  logic               fetch_valid,
    input  instr_t             fetch_instr,
    output logic               fetch_take,
    input  logic [N_LANES-1:0] lane_busy,
    output logic [N_LANES-1:0] issue_en,
    output issue_t             issue,
    input  logic               wb_valid,
    input  wb_t                wb,
    output logic               halt
);

    logic [XLEN-1:0]    regs [NREG];
    logic [NREG-1:0]    busy;
    logic               halt_seen;
    logic               halt_q;

    logic               is_halt;
    logic               uses_rs;
    logic               busy_hazard;
    logic               wb_hazard;
    logic [N_LANES-1:0] lane_idle;
    logic [N_LANES-1:0] lane_pick;
    logic               issue_go;
    logic               core_empty;

    assign is_halt = (fetch_instr.op == OP_HALT);

    // load immediate reads no source registers
    assign uses_rs = (fetch_instr.op != OP_LI);

    always_comb begin
        busy_hazard = busy[fetch_instr.rd];
        if (uses_rs) begin
            busy_hazard = busy_hazard || busy[fetch_instr.rs1] || busy[fetch_instr.rs2];
        end
    end

    // a register being written back this cycle is not yet readable
    always_comb begin
        wb_hazard = 1'b0;
        if (wb_valid) begin
            wb_hazard = (wb.rd == fetch_instr.rd);
            if (uses_rs) begin
                wb_hazard = wb_hazard || (wb.rd == fetch_instr.rs1)
                                      || (wb.rd == fetch_instr.rs2);
            end
        end
    end

    // lowest idle lane, isolated as a one-hot
    assign lane_idle = ~lane_busy;
    assign lane_pick = lane_idle & (~lane_idle + 1'b1);

    assign issue_go   = fetch_valid && !is_halt && !busy_hazard && !wb_hazard
                        && (|lane_idle);
    assign issue_en   = issue_go ? lane_pick : '0;
    assign fetch_take = issue_go || (fetch_valid && is_halt);

    // operand read straight from the register file
    assign issue.op  = fetch_instr.op;
    assign issue.rd  = fetch_instr.rd;
    assign issue.opa = regs[fetch_instr.rs1];
    assign issue.opb = regs[fetch_instr.rs2];
    assign issue.imm = fetch_instr.imm;

    // register file starts cleared
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < NREG; r++) begin
                regs[r] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb.rd] <= wb.wdat;
        end
    end

    // clear on writeback, set on issue; same register cannot do both in one cycle
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb.rd] <= 1'b0;
            end
            if (issue_go) begin
                busy[fetch_instr.rd] <= 1'b1;
            end
        end
    end

    // nothing in flight once every busy bit and every lane is clear
    assign core_empty = !(|busy) && !(|lane_busy);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_seen <= 1'b0;
            halt_q    <= 1'b0;
        end else begin
            if (fetch_valid && is_halt) begin
                halt_seen <= 1'b1;
            end
            // sticky until reset
            if (halt_seen && core_empty) begin
                halt_q <= 1'b1;
            end
        end
    end

    assign halt = halt_q;

endmodule

// ==== verilog/alu_lane.sv ====
// execution lane, single-step logic ops and bit-serial shifts, result held until granted
`timescale 1ns/1ps

module alu_lane
    import datapath_pkg::*;
(
    input  logic   CLK,
    input  logic   nrst,
    input  logic   issue_en,
    input  issue_t issue,
    output logic   lane_busy,
    output logic   done,
    output wb_t    res,
    input  logic   grant
);

    lane_state_t     state;
    wb_t             res_q;
    logic [3:0]      cnt;
    logic            shift_left;

    logic            is_shift;
    logic [3:0]      amount;
    logic [XLEN-1:0] quick;

    assign is_shift = (issue.op == OP_SLL) || (issue.op == OP_SRL);

    // shift amount from the low nibble of rs2
    assign amount = issue.opb[3:0];

    always_comb begin
        case (issue.op)
            OP_ADD:  quick = issue.opa + issue.opb;
            OP_SUB:  quick = issue.opa - issue.opb;
            OP_AND:  quick = issue.opa & issue.opb;
            OP_OR:   quick = issue.opa | issue.opb;
            OP_XOR:  quick = issue.opa ^ issue.opb;
            OP_LI:   quick = {{(XLEN-8){1'b0}}, issue.imm};
            // zero-amount shift passes the operand through
            default: quick = issue.opa;
        endcase
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state <= LANE_IDLE;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (issue_en) begin
                        if (is_shift && (amount != 4'd0)) begin
                            state <= LANE_BUSY;
                        end else begin
                            state <= LANE_DONE;
                        end
                    end
                end
                LANE_BUSY: begin
                    // last bit position this cycle
                    if (cnt == 4'd1) begin
                        state <= LANE_DONE;
                    end
                end
                LANE_DONE: begin
                    if (grant) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // working value lives in the result register while shifting
    always_ff @(posedge CLK) begin
        if ((state == LANE_IDLE) && issue_en) begin
            res_q.rd   <= issue.rd;
            res_q.wdat <= quick;
            cnt        <= amount;
            shift_left <= (issue.op == OP_SLL);
        end else if (state == LANE_BUSY) begin
            res_q.wdat <= shift_left ? (res_q.wdat << 1) : (res_q.wdat >> 1);
            cnt        <= cnt - 4'd1;
        end
    end

    assign lane_busy = (state != LANE_IDLE);
    assign done      = (state == LANE_DONE);
    assign res       = res_q;

endmodule

// ==== verilog/writeback.sv ====
// writeback, round-robin drain of finished lanes into one registered result stream
`timescale 1ns/1ps

module writeback
    import datapath_pkg::*;
#(
    parameter int N_LANES = 3
)
(
    input  logic               CLK,
    input  logic               nrst,
    input  logic [N_LANES-1:0] done,
    input  wb_t                res [N_LANES],
    output logic [N_LANES-1:0] grant,
    output logic               wb_valid,
    output wb_t                wb
);

    localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] grant_idx;
    logic             any_grant;

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = last_q;
        any_grant = 1'b0;
        for (int k = 1; k <= N_LANES; k++) begin
            idx = (int'(last_q) + k) % N_LANES;
            if (!any_grant && done[idx]) begin
                any_grant      = 1'b1;
                grant[idx]     = 1'b1;
                grant_idx      = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_valid <= 1'b0;
            last_q   <= PTR_W'(N_LANES - 1);
        end else begin
            wb_valid <= any_grant;
            if (any_grant) begin
                last_q <= grant_idx;
            end
        end
    end

    // result payload, qualified by wb_valid
    always_ff @(posedge CLK) begin
        if (any_grant) begin
            wb <= res[grant_idx];
        end
    end

endmodule

// ==== verilog/sc_datapath.sv ====
// scalar datapath top, fetch into scoreboard, parallel ALU lanes and round-robin writeback
`timescale 1ns/1ps

module sc_datapath
    import datapath_pkg::*;
#(
    parameter int N_LANES = 3
)
(
    input  logic   CLK,
    input  logic   nrst,
    input  logic   instr_req,
    input  instr_t instr,
    output logic   instr_ack,
    output logic   wb_valid,
    output wb_t    wb,
    output logic   halt
);

    logic               fetch_valid;
    instr_t             fetch_instr;
    logic               fetch_take;

    logic [N_LANES-1:0] lane_busy;
    logic [N_LANES-1:0] issue_en;
    issue_t             issue;

    logic [N_LANES-1:0] lane_done;
    logic [N_LANES-1:0] lane_grant;
    wb_t                lane_res [N_LANES];

    fetch_stage i_fetch (
        .CLK         (CLK),
        .nrst        (nrst),
        .instr_req   (instr_req),
        .instr       (instr),
        .instr_ack   (instr_ack),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_take  (fetch_take)
    );

    scoreboard #(.N_LANES(N_LANES)) i_scoreboard (
        .CLK         (CLK),
        .nrst        (nrst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_take  (fetch_take),
        .lane_busy   (lane_busy),
        .issue_en    (issue_en),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .halt        (halt)
    );

    // identical lanes sharing one issue bundle
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        alu_lane i_lane (
            .CLK       (CLK),
            .nrst      (nrst),
            .issue_en  (issue_en[i]),
            .issue     (issue),
            .lane_busy (lane_busy[i]),
            .done      (lane_done[i]),
            .res       (lane_res[i]),
            .grant     (lane_grant[i])
        );
    end

    writeback #(.N_LANES(N_LANES)) i_writeback (
        .CLK      (CLK),
        .nrst     (nrst),
        .done     (lane_done),
        .res      (lane_res),
        .grant    (lane_grant),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

// ==== dv/tb_sc_datapath.sv ====
// testbench for the scalar datapath core, random program checked against an in-order model
`timescale 1ns/1ps

module tb_sc_datapath
    import datapath_pkg::*;
();

    localparam int PROG_LEN   = 200;
    localparam int MAX_CYCLES = PROG_LEN * (4 + 3 + 16 + 4) + 100;

    logic   CLK;
    logic   nrst;
    logic   instr_req;
    instr_t instr;
    logic   instr_ack;
    logic   wb_valid;
    wb_t    wb;
    logic   halt;

    instr_t          prog [PROG_LEN + 1];
    logic [XLEN-1:0] model_regs [NREG];
    logic [XLEN-1:0] exp_q [NREG][$];
    int              n_writes;
    int              wb_count;
    int              cycle_count;
    logic [31:0]     lcg_state;
    logic            prev_ack;
    logic            prev_req;

    sc_datapath i_sc_datapath (
        .CLK       (CLK),
        .nrst      (nrst),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .halt      (halt)
    );

    always begin
        #20;
        CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]};
    endfunction

    function automatic logic [REG_W-1:0] rand_reg();
        logic [31:0] r;
        r = next_rand();
        return r[REG_W-1:0];
    endfunction

    // ISA semantics, shifts take the low nibble of rs2
    function automatic logic [XLEN-1:0] model_result(instr_t w, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        case (w.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[3:0];
            OP_SRL:  return a >> b[3:0];
            OP_LI:   return {8'd0, w.imm};
            default: return '0;
        endcase
    endfunction

    function automatic int pending_results();
        int total;
        total = 0;
        for (int r = 0; r < NREG; r++) begin
            total = total + exp_q[r].size();
        end
        return total;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic stop_run(string what);
        $display("ERROR: %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic build_program();
        int          n;
        int          pick;
        logic [3:0]  amt;
        logic [31:0] r;
        instr_t      w;
        instr_t      ld;
        n   = 0;
        amt = 4'd0;
        while (n < PROG_LEN) begin
            pick  = int'(next_rand() % 32'd6);
            w     = '0;
            w.rd  = rand_reg();
            w.rs1 = rand_reg();
            w.rs2 = rand_reg();
            r     = next_rand();
            w.imm = r[7:0];
            if (pick == 0) begin
                w.op = OP_LI;
            end else if ((pick == 1) && (n < PROG_LEN - 1)) begin
                // preload rs2 so shift amounts walk through 0..15
                ld     = '0;
                ld.op  = OP_LI;
                ld.rd  = w.rs2;
                ld.imm = {r[11:8], amt};
                prog[n] = ld;
                n   = n + 1;
                amt = amt + 4'd1;
                w.op = r[12] ? OP_SLL : OP_SRL;
            end else begin
                w.op = opcode_t'({1'b0, r[15:13] % 3'd5});
            end
            prog[n] = w;
            n = n + 1;
        end
        prog[PROG_LEN]    = '0;
        prog[PROG_LEN].op = OP_HALT;
    endtask

    // in-order execution, one expected queue per destination register
    task automatic run_model();
        logic [XLEN-1:0] v;
        instr_t          w;
        n_writes = 0;
        for (int r = 0; r < NREG; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w = prog[i];
            v = model_result(w, model_regs[w.rs1], model_regs[w.rs2]);
            model_regs[w.rd] = v;
            exp_q[w.rd].push_back(v);
            n_writes = n_writes + 1;
        end
    endtask

    // one four-phase transfer after a few idle cycles
    task automatic send_instr(instr_t w, int idle);
        repeat (idle) begin
            @(posedge CLK);
            #2;
        end
        instr     = w;
        instr_req = 1'b1;
        do begin
            @(posedge CLK);
            #2;
        end while (!instr_ack);
        instr_req = 1'b0;
        do begin
            @(posedge CLK);
            #2;
        end while (instr_ack);
    endtask

    // protocol, writeback and halt checks at the falling edge
    always @(negedge CLK) begin : monitor
        logic [XLEN-1:0] want;
        if (!nrst) begin
            if (instr_ack !== 1'b0) begin
                stop_run("instr_ack is high during reset");
            end
        end else if (instr_ack && !prev_ack && !prev_req) begin
            stop_run("instr_ack rose while instr_req was low");
        end else if (!instr_ack && prev_ack && prev_req) begin
            stop_run("instr_ack fell while instr_req was still high");
        end else if (wb_valid && halt) begin
            stop_run("writeback seen after halt was raised");
        end else if (wb_valid && (exp_q[wb.rd].size() == 0)) begin
            stop_run($sformatf("writeback to r%0d with no result pending", wb.rd));
        end else begin
            if (wb_valid) begin
                want = exp_q[wb.rd].pop_front();
                check_value($sformatf("writeback r%0d", wb.rd), 32'(want), 32'(wb.wdat));
                wb_count = wb_count + 1;
            end
            if (halt) begin
                check_value("results pending at halt", 0, 32'(pending_results()));
            end
        end
        prev_ack = instr_ack;
        prev_req = instr_req;
    end

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: run hung before halt after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] r;
        CLK         = 1'b0;
        nrst        = 1'b0;
        instr_req   = 1'b0;
        instr       = '0;
        lcg_state   = 32'd78;
        cycle_count = 0;
        wb_count    = 0;
        prev_ack    = 1'b0;
        prev_req    = 1'b0;
        build_program();
        run_model();
        repeat (10) @(posedge CLK);
        #2;
        nrst = 1'b1;
        for (int i = 0; i <= PROG_LEN; i++) begin
            r = next_rand();
            send_instr(prog[i], int'(r % 32'd4));
        end
        while (halt !== 1'b1) begin
            @(negedge CLK);
        end
        // extra cycles to catch a stray writeback
        repeat (8) @(negedge CLK);
        check_value("writeback count", 32'(n_writes), 32'(wb_count));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/datapath_pkg.sv
verilog/fetch_stage.sv
verilog/scoreboard.sv
verilog/alu_lane.sv
verilog/writeback.sv
verilog/sc_datapath.sv
dv/tb_sc_datapath.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = tb_sc_datapath
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
